// ==== Bender.yml ====
package:
  name: kcpu_busunit

export_include_dirs:
  - logic

sources:
  # design, package first
  - files:
      - logic/kcpu_pkg.sv
      - logic/kcpu_bus_if.sv
      - logic/kcpu_cycle_timer.sv
      - logic/kcpu_seq.sv
      - logic/kcpu_memctrl.sv
      - logic/kcpu_busunit.sv

  # simulation only
  - target: test
    files:
      - tests/kcpu_busunit_mem.sv
      - tests/kcpu_busunit_tb.sv

// ==== kcpu_busunit.f ====
+incdir+logic
logic/kcpu_pkg.sv
logic/kcpu_bus_if.sv
logic/kcpu_cycle_timer.sv
logic/kcpu_seq.sv
logic/kcpu_memctrl.sv
logic/kcpu_busunit.sv
tests/kcpu_busunit_mem.sv
tests/kcpu_busunit_tb.sv

// ==== logic/kcpu_bus_if.sv ====
// byte-cycle control from the sequencer to the memory controller, one instance per bus unit
`timescale 1ns/10ps

interface kcpu_bus_if;

    logic start;     // one clock, load address and write word
    logic second;    // one clock, step address to the low byte
    logic byte_end;  // last clock of a byte cycle
    logic hi_phase;  // current byte is the high half of a word
    logic is_write;  // store access
    logic is_op;     // opcode fetch, byte goes to op

    // sequencer side
    modport seq (
        output start,
        output second,
        output byte_end,
        output hi_phase,
        output is_write,
        output is_op
    );

    // memory controller side
    modport mem (
        input start,
        input second,
        input byte_end,
        input hi_phase,
        input is_write,
        input is_op
    );

endinterface

// ==== logic/kcpu_busunit.sv ====
// memory bus unit top: joins sequencer, cycle timer and memory controller for the CPU core
`timescale 1ns/10ps

module kcpu_busunit (
    input  logic                   clk,
    input  logic                   rst,

    // request from the control unit
    input  logic                   req,      // one clock strobe
    input  kcpu_pkg::access_kind_t kind,
    input  kcpu_pkg::addr_src_t    src,
    input  kcpu_pkg::addr_t        pc,
    input  kcpu_pkg::addr_t        regs_x,
    input  kcpu_pkg::addr_t        regs_y,
    input  kcpu_pkg::addr_t        idx_addr,
    input  logic                   idx_adv,
    input  logic [3:0]             intvec,   // one-hot
    input  kcpu_pkg::word_t        wdata,

    // memory side
    input  kcpu_pkg::byte_t        din,
    output kcpu_pkg::addr_t        addr,
    output kcpu_pkg::byte_t        dout,
    output logic                   we,

    // results back to the control unit
    output kcpu_pkg::word_t        data,
    output kcpu_pkg::byte_t        op,
    output logic                   busy,
    output logic                   done
);

    logic cycle_start;  // sequencer to timer
    logic cycle_last;   // timer to sequencer

    kcpu_bus_if i_bus ();

    kcpu_seq i_seq (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .kind        (kind),
        .cycle_last  (cycle_last),
        .cycle_start (cycle_start),
        .busy        (busy),
        .done        (done),
        .bus         (i_bus.seq)
    );

    kcpu_cycle_timer i_timer (
        .clk         (clk),
        .rst         (rst),
        .cycle_start (cycle_start),
        .cycle_last  (cycle_last)
    );

    kcpu_memctrl i_memctrl (
        .clk      (clk),
        .rst      (rst),
        .src      (src),
        .pc       (pc),
        .regs_x   (regs_x),
        .regs_y   (regs_y),
        .idx_addr (idx_addr),
        .idx_adv  (idx_adv),
        .intvec   (intvec),
        .wdata    (wdata),
        .din      (din),
        .bus      (i_bus.mem),
        .addr     (addr),
        .dout     (dout),
        .we       (we),
        .data     (data),
        .op       (op)
    );

endmodule

// ==== logic/kcpu_cycle_timer.sv ====
// byte-cycle timer: counts wait states and flags the last clock of each memory byte cycle
`timescale 1ns/10ps

`include "kcpu_defs.svh"

module kcpu_cycle_timer (
    input  logic clk,
    input  logic rst,
    input  logic cycle_start,  // load, first clock of the cycle follows
    output logic cycle_last    // final clock of the byte cycle
);

    // enough bits for the wait-state count, at least one
    localparam int CNT_W = (`KCPU_WAIT_STATES > 0) ? $clog2(`KCPU_WAIT_STATES + 1) : 1;

    logic [CNT_W-1:0] cnt;      // clocks left after this one
    logic             running;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            running <= 1'b0;
        end else if (cycle_start) begin
            // a reload wins over the end of the previous cycle
            cnt     <= CNT_W'(`KCPU_WAIT_STATES);
            running <= 1'b1;
        end else if (running) begin
            if (cnt == '0) begin
                running <= 1'b0;       // cycle over
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // with zero wait states this is high on the clock right after the load
    assign cycle_last = running && (cnt == '0);

endmodule

// ==== logic/kcpu_defs.svh ====
// bus unit constants: vector addresses, reset address and wait states, include where needed
`ifndef KCPU_DEFS_SVH
`define KCPU_DEFS_SVH

// interrupt vector table, top of the 64 KiB map
// each vector is a big-endian word, high byte at the lower address
`define KCPU_RST_VEC  16'hFFFE  // reset, also the address after rst
`define KCPU_NMI_VEC  16'hFFFC  // non-maskable
`define KCPU_IRQ_VEC  16'hFFF8  // normal interrupt
`define KCPU_FIRQ_VEC 16'hFFF6  // fast interrupt

// extra clocks added to every byte cycle
// a byte cycle lasts KCPU_WAIT_STATES+1 clocks,
// 0 gives single-clock byte cycles
`define KCPU_WAIT_STATES 1

// request-to-done latency for a B-byte access is 1 + B*(KCPU_WAIT_STATES+1)
// the extra clock is the DONE state of the sequencer

`endif

// ==== logic/kcpu_memctrl.sv ====
// memory controller: address mux and step, write-data select and read-data capture for the bus
`timescale 1ns/10ps

`include "kcpu_defs.svh"

module kcpu_memctrl (
    input  logic                clk,
    input  logic                rst,

    // address sources, sampled on start
    input  kcpu_pkg::addr_src_t src,
    input  kcpu_pkg::addr_t     pc,
    input  kcpu_pkg::addr_t     regs_x,
    input  kcpu_pkg::addr_t     regs_y,
    input  kcpu_pkg::addr_t     idx_addr,
    input  logic                idx_adv,   // +1 on the indexed address
    input  logic [3:0]          intvec,    // one-hot interrupt code

    // store data, sampled on start
    input  kcpu_pkg::word_t     wdata,

    // async-read memory data
    input  kcpu_pkg::byte_t     din,

    kcpu_bus_if.mem             bus,

    output kcpu_pkg::addr_t     addr,
    output kcpu_pkg::byte_t     dout,
    output logic                we,
    output kcpu_pkg::word_t     data,      // assembled read word
    output kcpu_pkg::byte_t     op         // last opcode
);

    import kcpu_pkg::*;

    addr_t vec_addr;   // decoded vector
    addr_t idx_sum;
    addr_t first_addr; // address of the first byte
    word_t wword;      // store word held for the access

    // interrupt vector select
    always_comb begin
        case (intvec)
            4'b0001: vec_addr = `KCPU_IRQ_VEC;
            4'b0010: vec_addr = `KCPU_FIRQ_VEC;
            4'b0100: vec_addr = `KCPU_NMI_VEC;
            4'b1000: vec_addr = `KCPU_RST_VEC;
            default: vec_addr = `KCPU_RST_VEC;  // no code or several bits set
        endcase
    end

    assign idx_sum = idx_addr + {15'd0, idx_adv};

    // source mux
    // the control unit sends VEC_FETCH requests with src set to SRC_VEC
    always_comb begin
        case (src)
            SRC_PC:  first_addr = pc;
            SRC_X:   first_addr = regs_x;
            SRC_Y:   first_addr = regs_y;
            SRC_IDX: first_addr = idx_sum;
            SRC_VEC: first_addr = vec_addr;
            default: first_addr = pc;
        endcase
    end

    // address register, held between accesses
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            addr <= `KCPU_RST_VEC;
        end else if (bus.start) begin
            addr <= first_addr;
        end else if (bus.second) begin
            addr <= addr + 16'd1;  // low byte follows the high one
        end
    end

    // store word, only meaningful while a write is in flight
    always_ff @(posedge clk) begin
        if (bus.start) begin
            wword <= wdata;
        end
    end

    // high half only for the first byte of WR_WORD
    assign dout = bus.hi_phase ? wword[15:8] : wword[7:0];

    // one clock per stored byte, memory writes on the closing edge
    assign we = bus.byte_end && bus.is_write;

    // read capture on the last clock of each byte cycle
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            data <= '0;
            op   <= '0;
        end else if (bus.byte_end && !bus.is_write) begin
            if (bus.is_op) begin
                op <= din;           // data left as it was
            end else if (bus.hi_phase) begin
                data[15:8] <= din;   // big-endian, high byte first
            end else begin
                data[7:0] <= din;    // low byte or single byte read
            end
        end
    end

endmodule

// ==== logic/kcpu_pkg.sv ====
// shared types of the bus unit: width typedefs and the enums for kind, source and state
package kcpu_pkg;

    typedef logic [15:0] addr_t;  // memory address
    typedef logic [ 7:0] byte_t;  // bus byte or opcode
    typedef logic [15:0] word_t;  // data word, big-endian in memory

    // request kinds sent by the control unit
    typedef enum logic [2:0] {
        OP_FETCH,   // one byte from pc into op
        RD_BYTE,    // one byte into data[7:0]
        RD_WORD,    // two bytes, high first
        WR_BYTE,    // wdata[7:0]
        WR_WORD,    // wdata high then low
        VEC_FETCH   // word from the vector table
    } access_kind_t;

    // where the first address of an access comes from
    typedef enum logic [2:0] {
        SRC_PC,
        SRC_X,
        SRC_Y,
        SRC_IDX,    // idx_addr + idx_adv
        SRC_VEC     // decoded from intvec
    } addr_src_t;

    typedef enum logic [1:0] {
        IDLE,
        FIRST,      // first (or only) byte cycle
        SECOND,     // low byte of a word
        DONE        // one clock, raises done
    } seq_state_t;

endpackage

// ==== logic/kcpu_seq.sv ====
// access sequencer: turns one request strobe into one or two byte cycles and a done pulse
`timescale 1ns/10ps

module kcpu_seq (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,         // one clock strobe from control unit
    input  kcpu_pkg::access_kind_t kind,
    input  logic                  cycle_last,  // from the timer
    output logic                  cycle_start, // (re)loads the timer
    output logic                  busy,
    output logic                  done,
    kcpu_bus_if.seq               bus
);

    import kcpu_pkg::*;

    seq_state_t   state;
    access_kind_t kind_q;     // kind of the access in flight
    logic         two_bytes;  // word access
    logic         accept;     // request taken this clock
    logic         step_hi;    // end of the high byte, go on to the low one

    // a req arriving while busy is dropped
    assign accept = (state == IDLE) && req;

    // properties of the latched kind
    always_comb begin
        two_bytes    = kind_q inside {RD_WORD, WR_WORD, VEC_FETCH};
        bus.is_write = kind_q inside {WR_BYTE, WR_WORD};
        bus.is_op    = (kind_q == OP_FETCH);
    end

    assign step_hi = (state == FIRST) && cycle_last && two_bytes;

    // state register
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            kind_q <= OP_FETCH;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state  <= FIRST;
                        kind_q <= kind;  // sampled with the operands
                    end
                end
                FIRST: begin
                    if (cycle_last) begin
                        state <= two_bytes ? SECOND : DONE;
                    end
                end
                SECOND: begin
                    if (cycle_last) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    state <= IDLE;  // done lasts a single clock
                end
                default: state <= IDLE;
            endcase
        end
    end

    // the address is loaded on the accept edge itself,
    // so start has to be combinational
    assign bus.start  = accept;
    assign bus.second = step_hi;   // memctrl bumps addr on this edge

    // timer starts with the request and again for the low byte
    assign cycle_start = accept | step_hi;

    // only a word's first byte is the high half
    assign bus.hi_phase = (state == FIRST) && two_bytes;

    // capture/write strobe follows the timer while a byte cycle runs
    assign bus.byte_end = cycle_last && ((state == FIRST) || (state == SECOND));

    assign busy = (state != IDLE);  // covers DONE too
    assign done = (state == DONE);

endmodule

// ==== tests/kcpu_busunit_mem.sv ====
// behavioral 64 KiB byte memory for the bus unit testbench, async read and clocked write
`timescale 1ns/10ps

module kcpu_busunit_mem (
    input  logic            clk,
    input  logic            we,     // one clock per stored byte
    input  kcpu_pkg::addr_t addr,
    input  kcpu_pkg::byte_t wdata,
    output kcpu_pkg::byte_t rdata
);

    import kcpu_pkg::*;

    byte_t mem [0:65535];

    assign rdata = mem[addr];  // asynchronous read

    // write lands on the edge that closes the byte cycle
    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // random fill, both address bytes folded in
    task preload(inout integer seed);
        int i;
        for (i = 0; i < 65536; i++) begin
            mem[i] = byte_t'($random(seed)) ^ byte_t'(i[15:8]) ^ byte_t'(i[7:0]);
        end
    endtask

    // backdoor read, no bus activity
    task peek(input addr_t a, output byte_t b);
        b = mem[a];
    endtask

endmodule

// ==== tests/kcpu_busunit_tb.sv ====
// testbench for the bus unit: drives requests on the falling edge and checks every done
`timescale 1ns/10ps

`include "kcpu_defs.svh"

module kcpu_busunit_tb;

    import kcpu_pkg::*;

    localparam int DONE_TIMEOUT = 40;  // clocks, well above the longest access

    // predicted outcome of one access
    typedef struct packed {
        word_t      data;
        byte_t      op;
        addr_t      last_addr;  // addr still on the bus at done
        logic [7:0] latency;    // clocks from sampling edge to done
        logic [1:0] n_wr;
        addr_t      wr_addr0;
        byte_t      wr_byte0;
        addr_t      wr_addr1;
        byte_t      wr_byte1;
    } expect_t;

    logic         clk = 1'b0;
    logic         rst;
    logic         req;
    access_kind_t kind;
    addr_src_t    src;
    addr_t        pc;
    addr_t        regs_x;
    addr_t        regs_y;
    addr_t        idx_addr;
    logic         idx_adv;
    logic [3:0]   intvec;
    word_t        wdata;
    byte_t        din;
    addr_t        addr;
    byte_t        dout;
    logic         we;
    word_t        data;
    byte_t        op;
    logic         busy;
    logic         done;

    integer       seed = 32'h3960_54e1;
    byte_t        shadow [0:65535];   // tb copy of memory
    word_t        model_data = '0;     // data/op as the unit should hold them
    byte_t        model_op = '0;
    expect_t      exp_q;               // access in flight
    logic [23:0]  wr_q [$];            // {addr, byte} still to be stored
    logic         pending = 1'b0;
    int           cyc = 0;
    int           req_cyc = 0;
    int           done_count = 0;
    int           err_count = 0;
    int           access_count = 0;
    int           wr_count = 0;
    addr_src_t    srcs [0:3] = '{SRC_PC, SRC_X, SRC_Y, SRC_IDX};

    always #5 clk = ~clk;  // 10 ns period

    always @(posedge clk) cyc <= cyc + 1;

    kcpu_busunit i_kcpu_busunit (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .kind     (kind),
        .src      (src),
        .pc       (pc),
        .regs_x   (regs_x),
        .regs_y   (regs_y),
        .idx_addr (idx_addr),
        .idx_adv  (idx_adv),
        .intvec   (intvec),
        .wdata    (wdata),
        .din      (din),
        .addr     (addr),
        .dout     (dout),
        .we       (we),
        .data     (data),
        .op       (op),
        .busy     (busy),
        .done     (done)
    );

    kcpu_busunit_mem i_mem (
        .clk   (clk),
        .we    (we),
        .addr  (addr),
        .wdata (dout),
        .rdata (din)
    );

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        $display("Error at %0t: %s = %0h, expected %0h", $time, name, got, expected);
        err_count++;
    endtask

    task automatic report_problem(input string what);
        $display("Error at %0t: %s", $time, what);
        err_count++;
    endtask

    // first address of an access from the source rules
    function automatic addr_t ref_addr(input addr_src_t s, input addr_t p, input addr_t x,
                                       input addr_t y, input addr_t ia, input logic adv,
                                       input logic [3:0] v);
        addr_t vec;
        if (v == 4'b0001) vec = `KCPU_IRQ_VEC;
        else if (v == 4'b0010) vec = `KCPU_FIRQ_VEC;
        else if (v == 4'b0100) vec = `KCPU_NMI_VEC;
        else vec = `KCPU_RST_VEC;  // 1000, zero and multi-bit codes
        case (s)
            SRC_PC:  ref_addr = p;
            SRC_X:   ref_addr = x;
            SRC_Y:   ref_addr = y;
            SRC_IDX: ref_addr = ia + addr_t'(adv);
            default: ref_addr = vec;
        endcase
    endfunction

    // data, op, writes and latency from the shadow memory
    function automatic expect_t predict(input access_kind_t k, input addr_t first,
                                        input word_t wd, input word_t old_data,
                                        input byte_t old_op);
        expect_t e;
        addr_t   nxt;
        int      nbytes;
        e      = '0;
        nxt    = first + 16'd1;  // wraps at the top of the map
        nbytes = (k == RD_WORD || k == WR_WORD || k == VEC_FETCH) ? 2 : 1;
        e.data      = old_data;
        e.op        = old_op;
        e.latency   = 8'(1 + nbytes * (`KCPU_WAIT_STATES + 1));
        e.last_addr = (nbytes == 2) ? nxt : first;
        case (k)
            OP_FETCH:           e.op = shadow[first];
            RD_BYTE:            e.data[7:0] = shadow[first];  // high half kept
            RD_WORD, VEC_FETCH: e.data = {shadow[first], shadow[nxt]};
            WR_BYTE: begin
                e.n_wr     = 2'd1;
                e.wr_addr0 = first;
                e.wr_byte0 = wd[7:0];
            end
            WR_WORD: begin
                e.n_wr     = 2'd2;
                e.wr_addr0 = first;
                e.wr_byte0 = wd[15:8];  // high byte first
                e.wr_addr1 = nxt;
                e.wr_byte1 = wd[7:0];
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic scramble_operands();
        int r;
        r        = $random(seed);
        pc       = addr_t'($random(seed));
        regs_x   = addr_t'($random(seed));
        regs_y   = addr_t'($random(seed));
        idx_addr = addr_t'($random(seed));
        wdata    = word_t'($random(seed));
        idx_adv  = r[0];
        intvec   = r[4:1];
    endtask

    // one request, waits for its done; extra_req fires a second req while busy
    task automatic run_access(input access_kind_t k, input addr_src_t s, input addr_t base,
                              input logic adv, input logic [3:0] vec, input word_t wd,
                              input logic extra_req);
        expect_t e;
        int      start_cnt;
        int      n;
        byte_t   b;
        @(negedge clk);
        scramble_operands();
        case (s)
            SRC_PC:  pc = base;
            SRC_X:   regs_x = base;
            SRC_Y:   regs_y = base;
            SRC_IDX: idx_addr = base;
            default: ;
        endcase
        kind    = k;
        src     = s;
        idx_adv = adv;
        intvec  = vec;
        wdata   = wd;
        req     = 1'b1;
        e = predict(k, ref_addr(s, pc, regs_x, regs_y, idx_addr, adv, vec), wd,
                    model_data, model_op);
        exp_q = e;
        if (e.n_wr > 0) wr_q.push_back({e.wr_addr0, e.wr_byte0});
        if (e.n_wr > 1) wr_q.push_back({e.wr_addr1, e.wr_byte1});
        start_cnt = done_count;
        pending <= 1'b1;
        req_cyc <= cyc;
        @(negedge clk);
        req = 1'b0;
        scramble_operands();  // the unit holds its own copy by now
        if (extra_req) begin
            kind = WR_WORD;
            src  = SRC_X;
            req  = 1'b1;      // unit is in FIRST, must drop this
            @(negedge clk);
            req  = 1'b0;
        end
        n = 0;
        while (done_count == start_cnt && n < DONE_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (done_count == start_cnt) report_problem("no done within the timeout");
        model_data = e.data;
        model_op   = e.op;
        if (e.n_wr > 0) begin
            shadow[e.wr_addr0] = e.wr_byte0;
            i_mem.peek(e.wr_addr0, b);
            if (b !== e.wr_byte0) value_error("mem byte", b, e.wr_byte0);
        end
        if (e.n_wr > 1) begin
            shadow[e.wr_addr1] = e.wr_byte1;
            i_mem.peek(e.wr_addr1, b);
            if (b !== e.wr_byte1) value_error("mem byte", b, e.wr_byte1);
        end
        access_count++;
        if (extra_req) repeat (2 * e.latency) @(posedge clk);  // room for a stray done
    endtask

    // output checks, all on the falling edge
    always @(negedge clk) begin : compare_outputs
        logic [23:0] w;
        if (!rst) begin
            if (pending && !busy) report_problem("busy low while an access is in flight");
            if (!pending && busy) report_problem("busy high with no access in flight");
            if (we) begin
                wr_count++;
                if (wr_q.size() == 0) begin
                    report_problem("write strobe with no byte left to store");
                end else begin
                    w = wr_q.pop_front();
                    if (addr !== w[23:8]) value_error("addr", addr, w[23:8]);
                    if (dout !== w[7:0]) value_error("dout", dout, w[7:0]);
                end
            end
            if (done) begin
                done_count++;
                if (!pending) begin
                    report_problem("done without an accepted request");
                end else begin
                    if (cyc - req_cyc != exp_q.latency)
                        value_error("done latency", cyc - req_cyc, exp_q.latency);
                    if (data !== exp_q.data) value_error("data", data, exp_q.data);
                    if (op !== exp_q.op) value_error("op", op, exp_q.op);
                    if (addr !== exp_q.last_addr) value_error("addr", addr, exp_q.last_addr);
                    if (wr_q.size() != 0) report_problem("done before every byte was stored");
                    pending <= 1'b0;
                end
            end
        end
    end

    initial begin : stimulus
        int    i;
        addr_t a;
        word_t w;
        byte_t b;
        rst      = 1'b1;
        req      = 1'b0;
        kind     = OP_FETCH;
        src      = SRC_PC;
        pc       = '0;
        regs_x   = '0;
        regs_y   = '0;
        idx_addr = '0;
        idx_adv  = 1'b0;
        intvec   = '0;
        wdata    = '0;
        i_mem.preload(seed);
        for (i = 0; i < 65536; i++) begin
            i_mem.peek(addr_t'(i), b);
            shadow[i] = b;
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (addr !== `KCPU_RST_VEC) value_error("addr", addr, `KCPU_RST_VEC);
        if (we !== 1'b0) value_error("we", we, 1'b0);
        if (busy !== 1'b0) value_error("busy", busy, 1'b0);
        if (done !== 1'b0) value_error("done", done, 1'b0);
        if (data !== 16'h0000) value_error("data", data, 16'h0000);
        if (op !== 8'h00) value_error("op", op, 8'h00);

        // opcode fetches
        for (i = 0; i < 8; i++)
            run_access(OP_FETCH, SRC_PC, addr_t'($random(seed)), 1'b0, 4'h0, 16'h0, 1'b0);

        // word reads over every register source, then byte reads
        run_access(RD_WORD, SRC_X, addr_t'($random(seed)), 1'b0, 4'h0, 16'h0, 1'b0);
        run_access(RD_WORD, SRC_Y, addr_t'($random(seed)), 1'b0, 4'h0, 16'h0, 1'b0);
        run_access(RD_WORD, SRC_IDX, addr_t'($random(seed)), 1'b0, 4'h0, 16'h0, 1'b0);
        run_access(RD_WORD, SRC_IDX, addr_t'($random(seed)), 1'b1, 4'h0, 16'h0, 1'b0);
        run_access(RD_WORD, SRC_IDX, 16'hFFFF, 1'b1, 4'h0, 16'h0, 1'b0);  // index wraps
        run_access(RD_WORD, SRC_X, 16'hFFFF, 1'b0, 4'h0, 16'h0, 1'b0);    // low byte at 0
        for (i = 0; i < 4; i++)
            run_access(RD_BYTE, srcs[i], addr_t'($random(seed)), 1'b1, 4'h0, 16'h0, 1'b0);

        // stores with read-back
        for (i = 0; i < 4; i++) begin
            a = addr_t'($random(seed));
            w = word_t'($random(seed));
            run_access(WR_BYTE, srcs[i], a, 1'b0, 4'h0, w, 1'b0);
            run_access(RD_BYTE, srcs[3 - i], a, 1'b0, 4'h0, 16'h0, 1'b0);
            if (data[7:0] !== w[7:0]) value_error("data[7:0]", data[7:0], w[7:0]);
            a = addr_t'($random(seed));
            w = word_t'($random(seed));
            run_access(WR_WORD, srcs[3 - i], a, 1'b0, 4'h0, w, 1'b0);
            run_access(RD_WORD, srcs[i], a, 1'b0, 4'h0, 16'h0, 1'b0);
            if (data !== w) value_error("data", data, w);
        end

        // vector fetches, one-hot then zero and multi-bit codes
        run_access(VEC_FETCH, SRC_VEC, 16'h0000, 1'b0, 4'b0001, 16'h0, 1'b0);
        run_access(VEC_FETCH, SRC_VEC, 16'h0000, 1'b0, 4'b0010, 16'h0, 1'b0);
        run_access(VEC_FETCH, SRC_VEC, 16'h0000, 1'b0, 4'b0100, 16'h0, 1'b0);
        run_access(VEC_FETCH, SRC_VEC, 16'h0000, 1'b0, 4'b1000, 16'h0, 1'b0);
        run_access(VEC_FETCH, SRC_VEC, 16'h0000, 1'b0, 4'b0000, 16'h0, 1'b0);
        run_access(VEC_FETCH, SRC_VEC, 16'h0000, 1'b0, 4'b0011, 16'h0, 1'b0);

        // second strobe while busy must vanish
        run_access(RD_WORD, SRC_Y, addr_t'($random(seed)), 1'b0, 4'h0, 16'h0, 1'b1);
        run_access(OP_FETCH, SRC_PC, addr_t'($random(seed)), 1'b0, 4'h0, 16'h0, 1'b1);
        run_access(WR_WORD, SRC_PC, addr_t'($random(seed)), 1'b0, 4'h0,
                   word_t'($random(seed)), 1'b1);

        repeat (4) @(negedge clk);
        $display("accesses: %0d, write strobes: %0d, errors: %0d",
                 access_count, wr_count, err_count);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
